/* rtl/accel_pkg.sv */
package accel_pkg;

    // Stream sample format
    localparam int DATA_WIDTH = 8;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    typedef enum logic [1:0] {
        ACT_PASS  = 2'd0,
        ACT_RELU  = 2'd1,
        ACT_LEAKY = 2'd2,
        ACT_RELU6 = 2'd3
    } act_mode_t;

    typedef enum logic {
        POOL_MAX = 1'b0,
        POOL_AVG = 1'b1
    } pool_type_t;

    // Negative slope of 1/8 in leaky mode
    localparam int LEAKY_SHIFT = 3;

    // 6.0 in Q4.4
    localparam sample_t RELU6_MAX = 8'sd96;

endpackage

/* rtl/csr_pkg.sv */
package csr_pkg;

    // Register bus geometry
    localparam int CSR_ADDR_WIDTH = 8;
    localparam int CSR_DATA_WIDTH = 32;
    localparam int CSR_STRB_WIDTH = CSR_DATA_WIDTH / 8;

    localparam int NUM_REGS      = 16;
    localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);

    // Region select sits in the top address bits
    localparam int REGION_WIDTH = 2;
    localparam logic [REGION_WIDTH-1:0] REGION_CSR = 2'd0;

    // Word indexes
    localparam logic [REG_IDX_WIDTH-1:0] REG_CTRL         = 4'd0;
    localparam logic [REG_IDX_WIDTH-1:0] REG_ACT_MODE     = 4'd4;
    localparam logic [REG_IDX_WIDTH-1:0] REG_POOL_MODE    = 4'd5;
    localparam logic [REG_IDX_WIDTH-1:0] REG_TOTAL_CYCLES = 4'd10;
    localparam logic [REG_IDX_WIDTH-1:0] REG_BUSY_CYCLES  = 4'd11;
    localparam logic [REG_IDX_WIDTH-1:0] REG_IDLE_CYCLES  = 4'd12;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    localparam int COUNTER_WIDTH = 32;

endpackage

/* rtl/csr_block.sv */
module csr_block (
    input  logic                                  clk,
    input  logic                                  sync_reset,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0]    awaddr,
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [csr_pkg::CSR_DATA_WIDTH-1:0]    wdata,
    input  logic [csr_pkg::CSR_STRB_WIDTH-1:0]    wstrb,
    output logic                                  bvalid,
    input  logic                                  bready,
    output logic [1:0]                            bresp,
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0]    araddr,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [csr_pkg::CSR_DATA_WIDTH-1:0]    rdata,
    output logic [1:0]                            rresp,
    input  logic [csr_pkg::COUNTER_WIDTH-1:0]     total_cycles,
    input  logic [csr_pkg::COUNTER_WIDTH-1:0]     busy_cycles,
    input  logic [csr_pkg::COUNTER_WIDTH-1:0]     idle_cycles,
    output logic                                  enable,
    output accel_pkg::act_mode_t                  act_mode,
    output accel_pkg::pool_type_t                 pool_type
);

    logic [csr_pkg::CSR_DATA_WIDTH-1:0] regs [csr_pkg::NUM_REGS];

    logic                                wr_take;
    logic                                wr_hit;
    logic [csr_pkg::REG_IDX_WIDTH-1:0]   wr_idx;
    logic                                rd_take;
    logic                                rd_hit;
    logic [csr_pkg::REG_IDX_WIDTH-1:0]   rd_idx;
    logic [csr_pkg::CSR_DATA_WIDTH-1:0]  rd_word;

    // Address and data must arrive together; one write outstanding at a time
    assign wr_take = awvalid && wvalid && !bvalid;
    assign rd_take = arvalid && !rvalid;

    assign wr_hit = awaddr[csr_pkg::CSR_ADDR_WIDTH-1 -: csr_pkg::REGION_WIDTH]
                    == csr_pkg::REGION_CSR;
    assign rd_hit = araddr[csr_pkg::CSR_ADDR_WIDTH-1 -: csr_pkg::REGION_WIDTH]
                    == csr_pkg::REGION_CSR;

    assign wr_idx = awaddr[2 +: csr_pkg::REG_IDX_WIDTH];
    assign rd_idx = araddr[2 +: csr_pkg::REG_IDX_WIDTH];

    // Counter words shadow the stored values on read
    always_comb begin
        case (rd_idx)
            csr_pkg::REG_TOTAL_CYCLES: rd_word = total_cycles;
            csr_pkg::REG_BUSY_CYCLES:  rd_word = busy_cycles;
            csr_pkg::REG_IDLE_CYCLES:  rd_word = idle_cycles;
            default:                   rd_word = regs[rd_idx];
        endcase
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            for (int i = 0; i < csr_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            awready <= wr_take;
            wready  <= wr_take;
            arready <= rd_take;

            if (wr_take) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_take) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_take && wr_hit) begin
                for (int b = 0; b < csr_pkg::CSR_STRB_WIDTH; b++) begin
                    if (wstrb[b]) begin
                        regs[wr_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Response payload
    always_ff @(posedge clk) begin
        if (wr_take) begin
            bresp <= wr_hit ? csr_pkg::RESP_OKAY : csr_pkg::RESP_DECERR;
        end
        if (rd_take) begin
            rdata <= rd_hit ? rd_word : '0;
            rresp <= rd_hit ? csr_pkg::RESP_OKAY : csr_pkg::RESP_DECERR;
        end
    end

    assign enable    = regs[csr_pkg::REG_CTRL][0];
    assign act_mode  = accel_pkg::act_mode_t'(regs[csr_pkg::REG_ACT_MODE][1:0]);
    assign pool_type = accel_pkg::pool_type_t'(regs[csr_pkg::REG_POOL_MODE][0]);

    assert property (@(posedge clk) disable iff (sync_reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (sync_reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read response changed before rready");

endmodule

/* rtl/activation_unit.sv */
module activation_unit (
    input  logic                 clk,
    input  logic                 sync_reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  accel_pkg::sample_t   in_data,
    input  logic                 in_last,
    input  accel_pkg::act_mode_t act_mode,
    output logic                 out_valid,
    input  logic                 out_ready,
    output accel_pkg::sample_t   out_data,
    output logic                 out_last
);

    accel_pkg::sample_t act_result;
    logic               in_fire;

    // Accept when empty or the held sample leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_comb begin
        case (act_mode)
            accel_pkg::ACT_RELU: begin
                act_result = (in_data < 0) ? '0 : in_data;
            end
            accel_pkg::ACT_LEAKY: begin
                act_result = (in_data < 0) ? (in_data >>> accel_pkg::LEAKY_SHIFT) : in_data;
            end
            accel_pkg::ACT_RELU6: begin
                if (in_data < 0) begin
                    act_result = '0;
                end else if (in_data > accel_pkg::RELU6_MAX) begin
                    act_result = accel_pkg::RELU6_MAX;
                end else begin
                    act_result = in_data;
                end
            end
            default: begin
                act_result = in_data;
            end
        endcase
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= act_result;
            out_last <= in_last;
        end
    end

    assert property (@(posedge clk) disable iff (sync_reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else $error("activation output changed while stalled");

endmodule

/* rtl/pool_unit.sv */
module pool_unit (
    input  logic                  clk,
    input  logic                  sync_reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  accel_pkg::sample_t    in_data,
    input  logic                  in_last,
    input  accel_pkg::pool_type_t pool_type,
    output logic                  out_valid,
    input  logic                  out_ready,
    output accel_pkg::sample_t    out_data,
    output logic                  out_last
);

    logic                                have_first;
    accel_pkg::sample_t                  first_data;
    logic                                in_fire;
    logic                                close;
    logic signed [accel_pkg::DATA_WIDTH:0] pair_sum;
    accel_pkg::sample_t                  pooled;

    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    // A pair closes on its second sample, or early on tlast
    assign close = in_fire && (have_first || in_last);

    // One extra bit keeps the pair sum exact
    assign pair_sum = first_data + in_data;

    always_comb begin
        if (!have_first) begin
            pooled = in_data;
        end else if (pool_type == accel_pkg::POOL_AVG) begin
            // Dropping the LSB floors toward minus infinity
            pooled = accel_pkg::sample_t'(pair_sum[accel_pkg::DATA_WIDTH:1]);
        end else begin
            pooled = (in_data > first_data) ? in_data : first_data;
        end
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            have_first <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (in_fire) begin
                have_first <= !close;
            end
            if (close) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire && !close) begin
            first_data <= in_data;
        end
        if (close) begin
            out_data <= pooled;
            out_last <= in_last;
        end
    end

    assert property (@(posedge clk) disable iff (sync_reset)
        out_valid && !out_ready |=> out_valid)
        else $error("pool output dropped before out_ready");

endmodule

/* rtl/perf_monitor.sv */
module perf_monitor (
    input  logic                              clk,
    input  logic                              sync_reset,
    input  logic                              busy,
    output logic [csr_pkg::COUNTER_WIDTH-1:0] total_cycles,
    output logic [csr_pkg::COUNTER_WIDTH-1:0] busy_cycles,
    output logic [csr_pkg::COUNTER_WIDTH-1:0] idle_cycles
);

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            total_cycles <= '0;
            busy_cycles  <= '0;
            idle_cycles  <= '0;
        end else begin
            total_cycles <= total_cycles + 1'b1;
            if (busy) begin
                busy_cycles <= busy_cycles + 1'b1;
            end else begin
                idle_cycles <= idle_cycles + 1'b1;
            end
        end
    end

    // Every cycle lands in exactly one bucket, wrap included
    assert property (@(posedge clk) disable iff (sync_reset)
        total_cycles == busy_cycles + idle_cycles)
        else $error("cycle counters out of balance");

endmodule

/* rtl/accel_top.sv */
module accel_top (
    input  logic                               clk,
    input  logic                               sync_reset,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] awaddr,
    input  logic                               wvalid,
    output logic                               wready,
    input  logic [csr_pkg::CSR_DATA_WIDTH-1:0] wdata,
    input  logic [csr_pkg::CSR_STRB_WIDTH-1:0] wstrb,
    output logic                               bvalid,
    input  logic                               bready,
    output logic [1:0]                         bresp,
    input  logic                               arvalid,
    output logic                               arready,
    input  logic [csr_pkg::CSR_ADDR_WIDTH-1:0] araddr,
    output logic                               rvalid,
    input  logic                               rready,
    output logic [csr_pkg::CSR_DATA_WIDTH-1:0] rdata,
    output logic [1:0]                         rresp,
    input  logic                               s_axis_tvalid,
    output logic                               s_axis_tready,
    input  accel_pkg::sample_t                 s_axis_tdata,
    input  logic                               s_axis_tlast,
    output logic                               m_axis_tvalid,
    input  logic                               m_axis_tready,
    output accel_pkg::sample_t                 m_axis_tdata,
    output logic                               m_axis_tlast
);

    logic                              enable;
    accel_pkg::act_mode_t              act_mode;
    accel_pkg::pool_type_t             pool_type;
    logic [csr_pkg::COUNTER_WIDTH-1:0] total_cycles;
    logic [csr_pkg::COUNTER_WIDTH-1:0] busy_cycles;
    logic [csr_pkg::COUNTER_WIDTH-1:0] idle_cycles;

    logic                              act_in_ready;
    logic                              act_valid;
    logic                              act_ready;
    accel_pkg::sample_t                act_data;
    logic                              act_last;
    logic                              busy;

    // Stream input is closed while disabled
    assign s_axis_tready = enable && act_in_ready;

    assign busy = act_valid || m_axis_tvalid;

    csr_block csr0 (
        .clk          (clk),
        .sync_reset   (sync_reset),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .total_cycles (total_cycles),
        .busy_cycles  (busy_cycles),
        .idle_cycles  (idle_cycles),
        .enable       (enable),
        .act_mode     (act_mode),
        .pool_type    (pool_type)
    );

    activation_unit act0 (
        .clk        (clk),
        .sync_reset (sync_reset),
        .in_valid   (s_axis_tvalid && enable),
        .in_ready   (act_in_ready),
        .in_data    (s_axis_tdata),
        .in_last    (s_axis_tlast),
        .act_mode   (act_mode),
        .out_valid  (act_valid),
        .out_ready  (act_ready),
        .out_data   (act_data),
        .out_last   (act_last)
    );

    pool_unit pool0 (
        .clk        (clk),
        .sync_reset (sync_reset),
        .in_valid   (act_valid),
        .in_ready   (act_ready),
        .in_data    (act_data),
        .in_last    (act_last),
        .pool_type  (pool_type),
        .out_valid  (m_axis_tvalid),
        .out_ready  (m_axis_tready),
        .out_data   (m_axis_tdata),
        .out_last   (m_axis_tlast)
    );

    perf_monitor perf0 (
        .clk          (clk),
        .sync_reset   (sync_reset),
        .busy         (busy),
        .total_cycles (total_cycles),
        .busy_cycles  (busy_cycles),
        .idle_cycles  (idle_cycles)
    );

endmodule

/* sim/accel_tb.sv */
module accel_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 1000;

    typedef enum {AW_READY, AR_READY, B_VALID, R_VALID, S_READY} hs_t;

    logic               clk = 1'b0;
    logic               sync_reset;
    logic               awvalid, awready, wvalid, wready, bvalid, bready;
    logic               arvalid, arready, rvalid, rready;
    logic [7:0]         awaddr, araddr;
    logic [31:0]        wdata, rdata;
    logic [3:0]         wstrb;
    logic [1:0]         bresp, rresp;
    logic               s_axis_tvalid, s_axis_tready, s_axis_tlast;
    logic               m_axis_tvalid, m_axis_tlast;
    logic               m_axis_tready = 1'b1;
    accel_pkg::sample_t s_axis_tdata, m_axis_tdata;

    // Expected outputs as {tlast, data}
    logic [8:0]  exp_q [$];
    logic [31:0] reg_model [16];
    int          half_val, cur_mode, cur_pool;
    bit          half_valid, bp_on, stream_closed;
    int          mismatches, failures;

    accel_top dut0 (.*);

    always #4 clk = ~clk;

    task automatic drive_tready();
        forever begin
            @(posedge clk);
            m_axis_tready <= !bp_on || ($urandom_range(0, 2) != 0);
        end
    endtask

    function automatic int act_ref(input int mode, input int x);
        int d;
        d = 1 << accel_pkg::LEAKY_SHIFT;
        case (mode)
            accel_pkg::ACT_RELU:  return (x < 0) ? 0 : x;
            // Floor division for the negative slope
            accel_pkg::ACT_LEAKY: return (x < 0) ? -((d - 1 - x) / d) : x;
            accel_pkg::ACT_RELU6: return (x < 0) ? 0 : ((x > accel_pkg::RELU6_MAX) ?
                                         int'(accel_pkg::RELU6_MAX) : x);
            default:              return x;
        endcase
    endfunction

    function automatic int pool_ref(input int ptype, input int a, input int b);
        int s;
        s = a + b;
        if (ptype == accel_pkg::POOL_MAX) begin
            return (a > b) ? a : b;
        end
        // Average rounds toward minus infinity
        return (s >= 0) ? s / 2 : -((1 - s) / 2);
    endfunction

    function automatic logic [7:0] word_addr(input int idx);
        return 8'(idx * 4);
    endfunction

    function automatic bit seen(input hs_t sel);
        case (sel)
            AW_READY: return awready;
            AR_READY: return arready;
            B_VALID:  return bvalid;
            R_VALID:  return rvalid;
            default:  return s_axis_tready;
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic log_failure(input string msg);
        failures++;
        $display("%s at %0t ns", msg, $time);
    endtask

    task automatic wait_for(input hs_t sel);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!seen(sel) && n < TIMEOUT);
        if (!seen(sel)) begin
            log_failure($sformatf("Timed out waiting for %s", sel.name()));
        end
    endtask

    task automatic bus_access(input bit write, input logic [7:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              output logic [31:0] rd, output logic [1:0] resp);
        if (write) begin
            {awvalid, wvalid} <= 2'b11;
            awaddr <= addr;
            wdata  <= data;
            wstrb  <= strb;
        end else begin
            arvalid <= 1'b1;
            araddr  <= addr;
        end
        wait_for(write ? AW_READY : AR_READY);
        {awvalid, wvalid, arvalid} <= 3'b000;
        // Hold the response channel off for a few cycles
        repeat ($urandom_range(1, 3)) @(posedge clk);
        {bready, rready} <= {write, !write};
        wait_for(write ? B_VALID : R_VALID);
        rd = rdata;
        resp = write ? bresp : rresp;
        {bready, rready} <= 2'b00;
    endtask

    task automatic write_word(input int idx, input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] rd;
        logic [1:0]  resp;
        bus_access(1'b1, word_addr(idx), data, strb, rd, resp);
        assert (resp == csr_pkg::RESP_OKAY)
            else report_mismatch($sformatf("bresp %0d writing word %0d", resp, idx));
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                reg_model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic check_word(input int idx);
        logic [31:0] rd;
        logic [1:0]  resp;
        bus_access(1'b0, word_addr(idx), '0, '0, rd, resp);
        assert (rd == reg_model[idx] && resp == csr_pkg::RESP_OKAY)
            else report_mismatch($sformatf("word %0d read %h resp %0d, expected %h",
                idx, rd, resp, reg_model[idx]));
    endtask

    task automatic configure(input int mode, input int ptype);
        write_word(csr_pkg::REG_ACT_MODE, mode, 4'hF);
        write_word(csr_pkg::REG_POOL_MODE, ptype, 4'hF);
        cur_mode = mode;
        cur_pool = ptype;
    endtask

    task automatic send_packet(input int len);
        for (int i = 0; i < len; i++) begin
            s_axis_tvalid <= 1'b1;
            s_axis_tdata  <= accel_pkg::sample_t'($urandom);
            s_axis_tlast  <= (i == len - 1);
            wait_for(S_READY);
        end
        s_axis_tvalid <= 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (exp_q.size() != 0 && n < TIMEOUT);
        if (exp_q.size() != 0) begin
            log_failure("Timed out waiting for expected outputs");
        end
    endtask

    // Model fed by accepted inputs and compared on delivered outputs
    always @(posedge clk) begin
        int         a;
        logic [8:0] want;
        if (!sync_reset && s_axis_tvalid && s_axis_tready) begin
            a = act_ref(cur_mode, s_axis_tdata);
            if (half_valid || s_axis_tlast) begin
                exp_q.push_back({s_axis_tlast,
                    8'(half_valid ? pool_ref(cur_pool, half_val, a) : a)});
            end else begin
                half_val = a;
            end
            half_valid = !half_valid && !s_axis_tlast;
        end
        if (!sync_reset && m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
                log_failure("Output sample arrived with none expected");
            end else begin
                want = exp_q.pop_front();
                assert ({m_axis_tlast, m_axis_tdata} == want)
                    else report_mismatch($sformatf("m_axis %0d last %0b, expected %0d last %0b",
                        m_axis_tdata, m_axis_tlast, $signed(want[7:0]), want[8]));
            end
        end
    end

    assert property (@(posedge clk) disable iff (sync_reset) bvalid && !bready |=> bvalid)
        else report_mismatch("bvalid dropped while bready was low");
    assert property (@(posedge clk) disable iff (sync_reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else report_mismatch("read response changed while rready was low");
    assert property (@(posedge clk) disable iff (sync_reset)
        (awready || wready) |-> (awready && wready && $rose(bvalid)) ##1 (!awready && !wready))
        else report_mismatch("write ready pulse out of step with bvalid");
    assert property (@(posedge clk) disable iff (sync_reset)
        arready |-> $rose(rvalid) ##1 !arready)
        else report_mismatch("read ready pulse out of step with rvalid");
    assert property (@(posedge clk) disable iff (sync_reset)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable({m_axis_tdata, m_axis_tlast}))
        else report_mismatch("m_axis output changed while stalled");
    assert property (@(posedge clk) stream_closed |-> !s_axis_tready)
        else report_mismatch("s_axis_tready high with enable cleared");

    initial begin
        logic [31:0] rd, total0, busy_n, idle_n;
        logic [1:0]  resp;
        void'($urandom(32'h118ebd16));
        sync_reset = 1'b1;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        {awaddr, wdata, wstrb, araddr} = '0;
        {s_axis_tvalid, s_axis_tdata, s_axis_tlast} = '0;
        foreach (reg_model[i]) begin
            reg_model[i] = '0;
        end
        fork
            drive_tready();
        join_none
        repeat (8) @(posedge clk);
        sync_reset <= 1'b0;

        // Scratch words get two strobed writes each
        for (int i = 1; i < 16; i++) begin
            if (i < 10 || i > 12) begin
                repeat (2) write_word(i, $urandom, 4'($urandom));
            end
        end
        for (int i = 1; i < 16; i++) begin
            if (i < 10 || i > 12) begin
                check_word(i);
            end
        end

        // Regions 1 to 3 alias word 1 but hold no storage
        for (int r = 1; r < 4; r++) begin
            bus_access(1'b1, 8'(r * 64 + 4), $urandom, 4'hF, rd, resp);
            assert (resp == csr_pkg::RESP_DECERR)
                else report_mismatch($sformatf("bresp %0d for region %0d", resp, r));
            bus_access(1'b0, 8'(r * 64 + 4), '0, '0, rd, resp);
            assert (resp == csr_pkg::RESP_DECERR && rd == '0)
                else report_mismatch($sformatf("region %0d read %h resp %0d", r, rd, resp));
            check_word(1);
        end

        write_word(csr_pkg::REG_CTRL, 32'd1, 4'hF);
        for (int m = 0; m < 4; m++) begin
            configure(m, accel_pkg::POOL_MAX);
            repeat (3) send_packet(2 * $urandom_range(1, 4));
            drain();
        end

        // Odd lengths leave a lone last sample
        configure(accel_pkg::ACT_PASS, accel_pkg::POOL_AVG);
        for (int len = 1; len < 10; len += 2) begin
            send_packet(len);
        end
        drain();

        configure($urandom_range(0, 3), $urandom_range(0, 1));
        bp_on <= 1'b1;
        repeat (6) send_packet($urandom_range(1, 9));
        drain();
        bp_on <= 1'b0;

        write_word(csr_pkg::REG_CTRL, 32'd0, 4'hF);
        stream_closed <= 1'b1;
        s_axis_tvalid <= 1'b1;
        repeat (16) @(posedge clk);
        s_axis_tvalid <= 1'b0;
        stream_closed <= 1'b0;
        write_word(csr_pkg::REG_CTRL, 32'd1, 4'hF);

        // Stream path is quiet from here on
        repeat (10) @(posedge clk);
        bus_access(1'b0, word_addr(csr_pkg::REG_TOTAL_CYCLES), '0, '0, total0, resp);
        bus_access(1'b0, word_addr(csr_pkg::REG_BUSY_CYCLES), '0, '0, busy_n, resp);
        bus_access(1'b0, word_addr(csr_pkg::REG_IDLE_CYCLES), '0, '0, idle_n, resp);
        assert (busy_n != 0 && busy_n + idle_n > total0)
            else report_mismatch($sformatf("counters total %0d busy %0d idle %0d",
                total0, busy_n, idle_n));
        repeat (20) @(posedge clk);
        bus_access(1'b0, word_addr(csr_pkg::REG_TOTAL_CYCLES), '0, '0, rd, resp);
        assert (rd > total0 && resp == csr_pkg::RESP_OKAY)
            else report_mismatch($sformatf("total_cycles %0d after %0d", rd, total0));

        $display("Checks finished with %0d mismatches and %0d other failures",
            mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* accel_top.f */
rtl/accel_pkg.sv
rtl/csr_pkg.sv
rtl/csr_block.sv
rtl/activation_unit.sv
rtl/pool_unit.sv
rtl/perf_monitor.sv
rtl/accel_top.sv
sim/accel_tb.sv
